/* rtl/config_bank.sv */
`timescale 1ns/10ps

module config_bank
	import dfe_pkg::*;
#(
	parameter int num_alu = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     cfg_we,
	input  logic [sel_w-1:0]         cfg_addr,
	input  alu_cfg_t                 cfg_data,
	input  logic                     cfg_commit,
	output alu_cfg_t [num_alu-1:0]   cfg_active
);

	alu_cfg_t [num_alu-1:0] shadow;
	logic [num_alu-1:0]     wr_hit;

	// address decode, out of range hits nothing
	always_comb begin
		wr_hit = '0;
		for (int i = 0; i < num_alu; i++) begin
			if (cfg_we && cfg_addr == sel_w'(i)) begin
				wr_hit[i] = 1'b1;
			end
		end
	end

	// shadow bank, one word per write
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			shadow <= '0;
		end else begin
			for (int i = 0; i < num_alu; i++) begin
				if (wr_hit[i]) begin
					shadow[i] <= cfg_data;
				end
			end
		end
	end

	// active bank
	// commit sees the shadow from before this edge
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cfg_active <= '0;
		end else if (cfg_commit) begin
			cfg_active <= shadow;
		end
	end

endmodule

/* rtl/dfe_pkg.sv */
package dfe_pkg;

	// width of one flow word
	localparam int data_w = 32;

	// flow-bus source index, at most 16 sources
	localparam int sel_w = 4;

	// leading-zero count fits 0..32
	localparam int lz_w = 6;

	// ALU function codes, add must stay at zero
	typedef enum logic [3:0] {
		fn_add     = 4'd0,
		fn_sub     = 4'd1,
		fn_or      = 4'd2,
		fn_and     = 4'd3,
		fn_xor     = 4'd4,
		fn_sext8   = 4'd5,
		fn_sext16  = 4'd6,
		fn_sra     = 4'd7,
		fn_srl     = 4'd8,
		fn_cmp_sig = 4'd9,
		fn_cmp_uns = 4'd10,
		fn_mux     = 4'd11,
		fn_clz     = 4'd12,
		fn_max     = 4'd13,
		fn_min     = 4'd14,
		fn_abs     = 4'd15
	} alu_fn_t;

	// configuration word of one ALU
	// all zero means add source 0 to itself
	typedef struct packed {
		logic [sel_w-1:0] sel_a;
		logic [sel_w-1:0] sel_b;
		alu_fn_t          fn;
	} alu_cfg_t;

endpackage

/* rtl/flow_alu.sv */
`timescale 1ns/10ps

module flow_alu
	import dfe_pkg::*;
#(
	parameter int num_src = 8
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [num_src-1:0][data_w-1:0] flow,
	input  alu_cfg_t                        cfg,
	output logic [data_w-1:0]               result
);

	logic [data_w-1:0] op_a;
	logic [data_w-1:0] op_b;
	logic [data_w-1:0] a_reg;
	logic [data_w-1:0] b_reg;

	// adder controls and operands, one bit wider than the data
	logic [data_w:0]   a_mask;
	logic [data_w:0]   b_mask;
	logic [data_w:0]   a_ext;
	logic [data_w:0]   b_ext;
	logic [data_w:0]   sum;
	logic              cin;
	logic              sign_ext;
	logic              b_lt_a;

	logic [lz_w-1:0]   lz;
	logic [data_w-1:0] res_next;

	// source select, anything past the bus reads as zero
	function automatic logic [data_w-1:0] pick(
		input logic [num_src-1:0][data_w-1:0] bus,
		input logic [sel_w-1:0]               sel
	);
		logic [data_w-1:0] word;
		word = '0;
		for (int i = 0; i < num_src; i++) begin
			if (sel == sel_w'(i)) begin
				word = bus[i];
			end
		end
		return word;
	endfunction

	assign op_a = pick(flow, cfg.sel_a);
	assign op_b = pick(flow, cfg.sel_b);

	// stage 1: operand capture
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			a_reg <= '0;
			b_reg <= '0;
		end else begin
			a_reg <= op_a;
			b_reg <= op_b;
		end
	end

	// adder setup per function
	// a_mask inverts a, b_mask clears b
	always_comb begin
		a_mask = '0;
		b_mask = '1;
		cin = 1'b0;
		sign_ext = 1'b0;
		case (cfg.fn)
			fn_sub, fn_cmp_uns: begin
				a_mask = '1;
				cin = 1'b1;
			end
			fn_cmp_sig, fn_max, fn_min: begin
				a_mask = '1;
				cin = 1'b1;
				sign_ext = 1'b1;
			end
			fn_abs: begin
				b_mask = '0;
				// negate only when a is negative
				if (a_reg[data_w-1]) begin
					a_mask = '1;
					cin = 1'b1;
				end
			end
			default: begin
			end
		endcase
	end

	assign a_ext = {sign_ext & a_reg[data_w-1], a_reg};
	assign b_ext = {sign_ext & b_reg[data_w-1], b_reg};

	// single 33-bit adder for add, sub, compares, max, min and abs
	assign sum = (b_ext & b_mask) + (a_ext ^ a_mask) + {{data_w{1'b0}}, cin};

	// sign of b - a
	assign b_lt_a = sum[data_w];

	lead_zero_count u_lzc (
		.value(a_reg),
		.count(lz)
	);

	// stage 2: function select
	always_comb begin
		res_next = sum[data_w-1:0];
		case (cfg.fn)
			fn_or: begin
				res_next = a_reg | b_reg;
			end
			fn_and: begin
				res_next = a_reg & b_reg;
			end
			fn_xor: begin
				res_next = a_reg ^ b_reg;
			end
			fn_sext8: begin
				res_next = {{(data_w-8){a_reg[7]}}, a_reg[7:0]};
			end
			fn_sext16: begin
				res_next = {{(data_w-16){a_reg[15]}}, a_reg[15:0]};
			end
			fn_sra: begin
				res_next = {a_reg[data_w-1], a_reg[data_w-1:1]};
			end
			fn_srl: begin
				res_next = {1'b0, a_reg[data_w-1:1]};
			end
			fn_cmp_sig, fn_cmp_uns: begin
				// top bit flags b < a, rest is the difference
				res_next[data_w-1] = b_lt_a;
			end
			fn_mux: begin
				res_next = a_reg[data_w-1] ? '0 : b_reg;
			end
			fn_clz: begin
				res_next = {{(data_w-lz_w){1'b0}}, lz};
			end
			fn_max: begin
				res_next = b_lt_a ? a_reg : b_reg;
			end
			fn_min: begin
				res_next = b_lt_a ? b_reg : a_reg;
			end
			default: begin
				// add, sub and abs take the adder output
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			result <= '0;
		end else begin
			result <= res_next;
		end
	end

endmodule

/* rtl/flow_engine.sv */
`timescale 1ns/10ps

module flow_engine
	import dfe_pkg::*;
#(
	parameter int num_in  = 4,
	parameter int num_alu = 4
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [num_in-1:0][data_w-1:0]  ext,
	input  logic                           cfg_we,
	input  logic [sel_w-1:0]               cfg_addr,
	input  alu_cfg_t                       cfg_data,
	input  logic                           cfg_commit,
	output logic [num_alu-1:0][data_w-1:0] result
);

	// external words first, then ALU results
	localparam int num_src = num_in + num_alu;

	logic [num_src-1:0][data_w-1:0] flow;
	alu_cfg_t [num_alu-1:0]         cfg_active;

	assign flow = {result, ext};

	config_bank #(
		.num_alu(num_alu)
	) u_cfg (
		.clk       (clk),
		.rst       (rst),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_data  (cfg_data),
		.cfg_commit(cfg_commit),
		.cfg_active(cfg_active)
	);

	// one ALU per result word, all on the same bus
	for (genvar j = 0; j < num_alu; j++) begin : g_alu
		flow_alu #(
			.num_src(num_src)
		) u_alu (
			.clk   (clk),
			.rst   (rst),
			.flow  (flow),
			.cfg   (cfg_active[j]),
			.result(result[j])
		);
	end

endmodule

/* rtl/lead_zero_count.sv */
`timescale 1ns/10ps

module lead_zero_count
	import dfe_pkg::*;
(
	input  logic [data_w-1:0] value,
	output logic [lz_w-1:0]   count
);

	// normalizing search, each stage shifts the zeros out of the top
	logic [data_w-1:0] v16;
	logic [data_w-1:0] v8;
	logic [data_w-1:0] v4;
	logic [data_w-1:0] v2;
	logic              z16;
	logic              z8;
	logic              z4;
	logic              z2;
	logic              z1;
	logic              all_zero;

	assign z16 = (value[31:16] == 16'h0);
	assign v16 = z16 ? {value[15:0], 16'h0} : value;

	assign z8 = (v16[31:24] == 8'h0);
	assign v8 = z8 ? {v16[23:0], 8'h0} : v16;

	assign z4 = (v8[31:28] == 4'h0);
	assign v4 = z4 ? {v8[27:0], 4'h0} : v8;

	assign z2 = (v4[31:30] == 2'b00);
	assign v2 = z2 ? {v4[29:0], 2'b00} : v4;

	assign z1 = ~v2[31];

	// the search alone tops out at 31
	assign all_zero = (value == '0);
	assign count = all_zero ? lz_w'(32) : {1'b0, z16, z8, z4, z2, z1};

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module flow_engine_tb -Mdir obj_dir
status=0
out=$(./obj_dir/Vflow_engine_tb) || status=$?
echo "$out"
if [ "$status" -eq 0 ] && echo "$out" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1

/* sources.f */
rtl/dfe_pkg.sv
rtl/lead_zero_count.sv
rtl/flow_alu.sv
rtl/config_bank.sv
rtl/flow_engine.sv
test/clock_gen.sv
test/flow_engine_props.sv
test/flow_engine_tb.sv

/* test/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen (
	output logic clk,
	output logic rst
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset over the first four rising edges
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* test/flow_engine_props.sv */
`timescale 1ns/10ps

module flow_engine_props
	import dfe_pkg::*;
(
	input logic              clk,
	input logic              rst,
	input alu_cfg_t          cfg,
	input logic [data_w-1:0] result
);

	// result register comes out of reset at zero
	reset_clears: assert property (@(posedge clk) rst |=> result == '0)
		else $error("result not zero after reset");

	// fn that produced the result is the one sampled an edge earlier
	clz_range: assert property (@(posedge clk) disable iff (rst)
		$past(cfg.fn) == fn_clz |-> result <= data_w)
		else $error("leading zero count above 32");

	sext8_fill: assert property (@(posedge clk) disable iff (rst)
		$past(cfg.fn) == fn_sext8 |-> result[data_w-1:8] == {(data_w-8){result[7]}})
		else $error("sext8 upper bits do not follow bit 7");

endmodule

bind flow_alu flow_engine_props u_props (
	.clk   (clk),
	.rst   (rst),
	.cfg   (cfg),
	.result(result)
);

/* test/flow_engine_tb.sv */
`timescale 1ns/10ps

module flow_engine_tb
	import dfe_pkg::*;
();

	localparam int num_in  = 4;
	localparam int num_alu = 4;

	localparam int reset_cycles   = 4;
	localparam int boot_cycles    = 12;
	localparam int fn_cycles      = 16 * (num_alu + 1 + 6);
	localparam int chain_cycles   = 4 * (num_alu + 1 + 12);
	localparam int shadow_cycles  = num_alu + 21;
	localparam int long_cycles    = 400;
	localparam int timeout_cycles = reset_cycles + boot_cycles + fn_cycles + chain_cycles +
		shadow_cycles + long_cycles + 100;

	logic                           clk;
	logic                           rst;
	logic [num_in-1:0][data_w-1:0]  ext;
	logic                           cfg_we;
	logic [sel_w-1:0]               cfg_addr;
	alu_cfg_t                       cfg_data;
	logic                           cfg_commit;
	logic [num_alu-1:0][data_w-1:0] result;

	// cycle model state
	alu_cfg_t          m_shadow [num_alu];
	alu_cfg_t          m_active [num_alu];
	logic [data_w-1:0] m_a [num_alu];
	logic [data_w-1:0] m_b [num_alu];
	logic [data_w-1:0] m_res [num_alu];

	logic [31:0] lfsr;
	int          cycle_count = 0;

	clock_gen u_clk (
		.clk(clk),
		.rst(rst)
	);

	flow_engine dut (
		.clk       (clk),
		.rst       (rst),
		.ext       (ext),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_data  (cfg_data),
		.cfg_commit(cfg_commit),
		.result    (result)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one LFSR step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// sign boundaries show up often
	function automatic logic [data_w-1:0] rand_data();
		logic [3:0]        pick;
		logic [data_w-1:0] w;
		pick = 4'(rand_bits(4));
		case (pick)
			4'd0: w = 32'h0000_0000;
			4'd1: w = 32'h0000_0001;
			4'd2: w = 32'hffff_ffff;
			4'd3: w = 32'h8000_0000;
			4'd4: w = 32'h7fff_ffff;
			default: w = rand_bits(32);
		endcase
		return w;
	endfunction

	function automatic alu_cfg_t make_cfg(input int a, input int b, input alu_fn_t fn);
		alu_cfg_t c;
		c.sel_a = sel_w'(a);
		c.sel_b = sel_w'(b);
		c.fn = fn;
		return c;
	endfunction

	function automatic alu_cfg_t ext_cfg(input alu_fn_t fn);
		return make_cfg(int'(rand_bits(2)), int'(rand_bits(2)), fn);
	endfunction

	// any source including out of range ones
	function automatic alu_cfg_t any_cfg();
		return make_cfg(int'(rand_bits(4)), int'(rand_bits(4)), alu_fn_t'(4'(rand_bits(4))));
	endfunction

	function automatic logic [data_w-1:0] bus_word(input logic [sel_w-1:0] sel);
		logic [data_w-1:0] w;
		w = '0;
		for (int i = 0; i < num_in; i++) begin
			if (int'(sel) == i) begin
				w = ext[i];
			end
		end
		for (int j = 0; j < num_alu; j++) begin
			if (int'(sel) == num_in + j) begin
				w = m_res[j];
			end
		end
		return w;
	endfunction

	function automatic logic [data_w-1:0] alu_model(input alu_fn_t fn,
		input logic [data_w-1:0] a, input logic [data_w-1:0] b);
		logic [data_w-1:0] r;
		logic [data_w-1:0] diff;
		logic              b_ge_a;
		int                n;
		r = '0;
		diff = b - a;
		b_ge_a = ($signed(b) >= $signed(a));
		case (fn)
			fn_add: r = a + b;
			fn_sub: r = diff;
			fn_or: r = a | b;
			fn_and: r = a & b;
			fn_xor: r = a ^ b;
			fn_sext8: r = {{24{a[7]}}, a[7:0]};
			fn_sext16: r = {{16{a[15]}}, a[15:0]};
			fn_sra: r = $signed(a) >>> 1;
			fn_srl: r = a >> 1;
			fn_cmp_sig: r = {($signed(b) < $signed(a)), diff[30:0]};
			fn_cmp_uns: r = {(b < a), diff[30:0]};
			fn_mux: r = a[31] ? '0 : b;
			fn_clz: begin
				n = 32;
				for (int i = 0; i < 32; i++) begin
					if (a[i]) n = 31 - i;
				end
				r = 32'(n);
			end
			fn_max: r = b_ge_a ? b : a;
			fn_min: r = b_ge_a ? a : b;
			fn_abs: r = a[31] ? -a : a;
		endcase
		return r;
	endfunction

	// one clock edge of the engine from the inputs it just sampled
	task automatic model_edge();
		logic [data_w-1:0] a_next [num_alu];
		logic [data_w-1:0] b_next [num_alu];
		logic [data_w-1:0] res_next [num_alu];
		for (int j = 0; j < num_alu; j++) begin
			a_next[j] = bus_word(m_active[j].sel_a);
			b_next[j] = bus_word(m_active[j].sel_b);
			res_next[j] = alu_model(m_active[j].fn, m_a[j], m_b[j]);
		end
		for (int j = 0; j < num_alu; j++) begin
			// commit takes the shadow from before the write
			if (cfg_commit) m_active[j] = m_shadow[j];
			if (cfg_we && int'(cfg_addr) == j) m_shadow[j] = cfg_data;
			m_a[j] = a_next[j];
			m_b[j] = b_next[j];
			m_res[j] = res_next[j];
		end
	endtask

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_results();
		for (int j = 0; j < num_alu; j++) begin
			assert (result[j] == m_res[j]) else begin
				$display("CHECK FAILED result[%0d] got %h expected %h", j, result[j], m_res[j]);
				abort_run();
			end
		end
	endtask

	task automatic run_cycle(input logic we, input logic [sel_w-1:0] addr, input alu_cfg_t data,
		input logic commit);
		logic [num_in-1:0][data_w-1:0] ext_next;
		for (int i = 0; i < num_in; i++) begin
			ext_next[i] = rand_data();
		end
		@(posedge clk);
		model_edge();
		ext <= ext_next;
		cfg_we <= we;
		cfg_addr <= addr;
		cfg_data <= data;
		cfg_commit <= commit;
		@(negedge clk);
		check_results();
	endtask

	task automatic idle(input int n);
		repeat (n) run_cycle(1'b0, '0, '0, 1'b0);
	endtask

	task automatic write_cfg(input int addr, input alu_cfg_t data);
		run_cycle(1'b1, sel_w'(addr), data, 1'b0);
	endtask

	task automatic commit_cfg();
		run_cycle(1'b0, '0, '0, 1'b1);
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		lfsr = 32'hccab;
		ext = '0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_data = '0;
		cfg_commit = 1'b0;
		for (int j = 0; j < num_alu; j++) begin
			m_shadow[j] = '0;
			m_active[j] = '0;
			m_a[j] = '0;
			m_b[j] = '0;
			m_res[j] = '0;
		end

		// results held at zero in reset and then ext[0] doubled
		@(negedge clk);
		check_results();
		wait (rst == 1'b0);
		idle(boot_cycles);

		// every function on external sources
		for (int f = 0; f < 16; f++) begin
			for (int j = 0; j < num_alu; j++) begin
				write_cfg(j, ext_cfg(alu_fn_t'(4'(f))));
			end
			commit_cfg();
			idle(6);
		end

		// fixed chain where alu2 also feeds itself
		// alu3 reads an empty source
		write_cfg(0, make_cfg(0, 1, fn_add));
		write_cfg(1, make_cfg(4, 2, fn_sub));
		write_cfg(2, make_cfg(5, 6, fn_xor));
		write_cfg(3, make_cfg(6, 12, fn_max));
		commit_cfg();
		idle(12);
		repeat (3) begin
			for (int j = 0; j < num_alu; j++) begin
				write_cfg(j, any_cfg());
			end
			commit_cfg();
			idle(12);
		end

		// shadow writes stay hidden until commit
		for (int j = 0; j < num_alu; j++) begin
			write_cfg(j, any_cfg());
		end
		idle(4);
		run_cycle(1'b1, '0, any_cfg(), 1'b1);
		idle(4);
		commit_cfg();
		idle(4);
		write_cfg(num_alu + int'(rand_bits(3)), any_cfg());
		write_cfg(15, any_cfg());
		commit_cfg();
		idle(4);

		repeat (long_cycles) begin
			run_cycle(1'(rand_bits(1)), sel_w'(rand_bits(3)), any_cfg(),
				3'(rand_bits(3)) == 3'd0);
		end

		$display("Simulation passed");
		$finish;
	end

endmodule
